// File: hw/csrAxiSlave.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module csrAxiSlave
(
	input  logic						iSCLK,
	input  logic						iSRST,
	// axi4-lite slave
	input  videoTxCsrPkg::csrAddr_t		awaddr,
	input  logic						awvalid,
	output logic						awready,
	input  videoTxCsrPkg::csrData_t		wdata,
	input  logic [`VTX_DATA_W/8-1:0]	wstrb,
	input  logic						wvalid,
	output logic						wready,
	output logic [1:0]					bresp,
	output logic						bvalid,
	input  logic						bready,
	input  videoTxCsrPkg::csrAddr_t		araddr,
	input  logic						arvalid,
	output logic						arready,
	output videoTxCsrPkg::csrData_t		rdata,
	output logic [1:0]					rresp,
	output logic						rvalid,
	input  logic						rready,
	// register side
	output videoTxCsrPkg::csrWrite_t	wrCmd,
	output videoTxCsrPkg::csrAddr_t		rdAddr,
	input  videoTxCsrPkg::csrData_t		rdData
);
	import videoTxCsrPkg::*;

	axiState_t	state;
	logic		wrAccept;
	logic		rdAccept;
	csrData_t	rdataQ;

	// --------------------------------------------------
	// handshakes
	// --------------------------------------------------
	// write needs both channels, any pending write blocks a read
	assign wrAccept = (state == idle) && awvalid && wvalid;
	assign rdAccept = (state == idle) && arvalid && !(awvalid || wvalid);

	assign awready = wrAccept;
	assign wready  = wrAccept;
	assign arready = rdAccept;

	// high only in the handshake cycle
	assign wrCmd.en   = wrAccept;
	assign wrCmd.addr = awaddr;
	assign wrCmd.data = wdata;	// full word, wstrb not decoded

	assign rdAddr = araddr;

	assign bvalid = (state == writeResp);
	assign bresp  = `VTX_RESP_OKAY;
	assign rvalid = (state == readResp);
	assign rresp  = `VTX_RESP_OKAY;
	assign rdata  = rdataQ;

	// --------------------------------------------------
	// one transaction in flight
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state <= idle;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (wrAccept)
						state <= writeResp;
					else if (rdAccept)
						state <= readResp;
				end
				writeResp:
				begin
					if (bready)
						state <= idle;
				end
				readResp:
				begin
					if (rready)
						state <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (rdAccept)
			rdataQ <= rdData;	// held until rready
	end

endmodule

// File: hw/csrReadMux.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module csrReadMux
(
	input  videoTxCsrPkg::csrAddr_t		rdAddr,
	input  videoTxCsrPkg::dmaCfg_t		dmaCfg,
	input  logic						vsgRst,
	input  videoTxCsrPkg::tftCfg_t		tftCfg,
	input  videoTxCsrPkg::mapCfg_t		mapCfg,
	input  videoTxCsrPkg::sceneCfg_t	sceneCfg,
	input  logic						sceneAlphaMax,
	input  logic						sceneAlphaMin,
	input  videoTxCsrPkg::hPos_t		pixelH,
	input  videoTxCsrPkg::vPos_t		pixelV,
	output videoTxCsrPkg::csrData_t		rdData
);

	always_comb
	begin
		rdData = '0;	// upper bits and unmapped offsets
		case (rdAddr)
			`VTX_REG_DMA_EN:		rdData[0] = dmaCfg.enable;
			`VTX_REG_DMA_CYCLE:		rdData[0] = dmaCfg.cycle;
			`VTX_REG_DMA_START:		rdData[`VTX_DMA_ADDR_W-1:0] = dmaCfg.startAddr;
			`VTX_REG_DMA_END:		rdData[`VTX_DMA_ADDR_W-1:0] = dmaCfg.endAddr;
			`VTX_REG_DMA_ADD:		rdData[`VTX_DMA_ADDR_W-1:0] = dmaCfg.stepAddr;
			`VTX_REG_VSG:			rdData[0] = vsgRst;
			`VTX_REG_TFT_DATA:		rdData[`VTX_TFT_DATA_W-1:0] = tftCfg.data;
			`VTX_REG_TFT_CTRL:
				rdData[`VTX_TFT_IM_W+5:0] = {tftCfg.im, tftCfg.gate, tftCfg.cs, tftCfg.rs,
					tftCfg.rd, tftCfg.wr, tftCfg.rst};
			`VTX_REG_MAP:			rdData[2*`VTX_MAP_W-1:0] = {mapCfg.xSize, mapCfg.ySize};
			`VTX_REG_SCENE_COLOR:	rdData[`VTX_COLOR_W-1:0] = sceneCfg.color;
			`VTX_REG_SCENE_TIME:	rdData[`VTX_SCENE_TIME_W-1:0] = sceneCfg.timing;
			`VTX_REG_SCENE_CTRL:
				rdData[2:0] = {sceneCfg.frameRst, sceneCfg.subEn, sceneCfg.addEn};
			// live status straight from the scene and pixel blocks
			`VTX_REG_SCENE_STAT:	rdData[1:0] = {sceneAlphaMax, sceneAlphaMin};
			`VTX_REG_PIXEL_POS:
			begin
				rdData[`VTX_DATA_W/2 +: `VTX_VPOS_W] = pixelV;
				rdData[`VTX_HPOS_W-1:0] = pixelH;
			end
			default:
				;
		endcase
	end

endmodule

// File: hw/csrRegFile.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module csrRegFile
(
	input  logic						iSCLK,
	input  logic						iSRST,
	input  videoTxCsrPkg::csrWrite_t	wrCmd,
	input  logic						dmaDone,
	output videoTxCsrPkg::dmaCfg_t		dmaCfg,
	output logic						vsgRst,
	output videoTxCsrPkg::tftCfg_t		tftCfg,
	output videoTxCsrPkg::mapCfg_t		mapCfg,
	output videoTxCsrPkg::sceneCfg_t	sceneCfg
);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dmaCfg.enable		<= 1'b0;
			dmaCfg.cycle		<= 1'b0;
			dmaCfg.startAddr	<= '0;
			dmaCfg.endAddr		<= '1;
			dmaCfg.stepAddr		<= '0;
			vsgRst				<= 1'b1;	// sync gen held until released
			tftCfg.data			<= '0;
			tftCfg.rst			<= 1'b0;
			tftCfg.wr			<= 1'b0;
			tftCfg.rd			<= 1'b0;
			tftCfg.rs			<= 1'b0;
			tftCfg.cs			<= 1'b1;	// panel deselected
			tftCfg.gate			<= 1'b1;
			tftCfg.im			<= '0;
			mapCfg.xSize		<= `VTX_MAP_X_RST;
			mapCfg.ySize		<= `VTX_MAP_Y_RST;
			sceneCfg.color		<= '0;
			sceneCfg.timing		<= '0;
			sceneCfg.addEn		<= 1'b0;
			sceneCfg.subEn		<= 1'b0;
			sceneCfg.frameRst	<= 1'b1;
		end
		else
		begin
			// --------------------------------------------------
			// host writes
			// --------------------------------------------------
			if (wrCmd.en)
			begin
				case (wrCmd.addr)
					`VTX_REG_DMA_EN:
						dmaCfg.enable <= wrCmd.data[0];
					`VTX_REG_DMA_CYCLE:
						dmaCfg.cycle <= wrCmd.data[0];
					`VTX_REG_DMA_START:
						dmaCfg.startAddr <= wrCmd.data[`VTX_DMA_ADDR_W-1:0];
					`VTX_REG_DMA_END:
						dmaCfg.endAddr <= wrCmd.data[`VTX_DMA_ADDR_W-1:0];
					`VTX_REG_DMA_ADD:
						dmaCfg.stepAddr <= wrCmd.data[`VTX_DMA_ADDR_W-1:0];
					`VTX_REG_VSG:
						vsgRst <= wrCmd.data[0];
					`VTX_REG_TFT_DATA:
						tftCfg.data <= wrCmd.data[`VTX_TFT_DATA_W-1:0];
					`VTX_REG_TFT_CTRL:
						{tftCfg.im, tftCfg.gate, tftCfg.cs, tftCfg.rs, tftCfg.rd, tftCfg.wr,
							tftCfg.rst} <= wrCmd.data[`VTX_TFT_IM_W+5:0];
					`VTX_REG_MAP:
						{mapCfg.xSize, mapCfg.ySize} <= wrCmd.data[2*`VTX_MAP_W-1:0];
					`VTX_REG_SCENE_COLOR:
						sceneCfg.color <= wrCmd.data[`VTX_COLOR_W-1:0];
					`VTX_REG_SCENE_TIME:
						sceneCfg.timing <= wrCmd.data[`VTX_SCENE_TIME_W-1:0];
					`VTX_REG_SCENE_CTRL:
						{sceneCfg.frameRst, sceneCfg.subEn, sceneCfg.addEn} <= wrCmd.data[2:0];
					default:
						;	// read-only or unmapped
				endcase
			end

			// end of frame buffer, rearm from auto-cycle
			// done beats a same-edge host write to enable
			if (dmaDone)
				dmaCfg.enable <= dmaCfg.cycle;
		end
	end

endmodule

// File: hw/videoTxCsrPkg.sv
`include "videoTxCsr_consts.svh"

package videoTxCsrPkg;

	// --------------------------------------------------
	// plain vectors
	// --------------------------------------------------
	typedef logic [`VTX_DATA_W-1:0]		csrData_t;
	typedef logic [`VTX_ADDR_W-1:0]		csrAddr_t;
	typedef logic [`VTX_DMA_ADDR_W-1:0]	dmaAddr_t;
	typedef logic [`VTX_HPOS_W-1:0]		hPos_t;
	typedef logic [`VTX_VPOS_W-1:0]		vPos_t;
	typedef logic [`VTX_COLOR_W-1:0]	color_t;
	typedef logic [`VTX_MAP_W-1:0]		mapSize_t;

	// --------------------------------------------------
	// config groups
	// --------------------------------------------------
	typedef struct packed {
		logic		enable;
		logic		cycle;		// reload value for enable on done
		dmaAddr_t	startAddr;
		dmaAddr_t	endAddr;
		dmaAddr_t	stepAddr;
	} dmaCfg_t;

	typedef struct packed {
		logic [`VTX_TFT_DATA_W-1:0]	data;
		logic						rst;
		logic						wr;
		logic						rd;
		logic						rs;		// data / command select
		logic						cs;
		logic						gate;
		logic [`VTX_TFT_IM_W-1:0]	im;		// panel interface mode
	} tftCfg_t;

	typedef struct packed {
		color_t							color;
		logic [`VTX_SCENE_TIME_W-1:0]	timing;	// frames per fade step
		logic							addEn;
		logic							subEn;
		logic							frameRst;
	} sceneCfg_t;

	typedef struct packed {
		mapSize_t	xSize;
		mapSize_t	ySize;
	} mapCfg_t;

	// single-cycle write from the bus side
	typedef struct packed {
		logic		en;
		csrAddr_t	addr;
		csrData_t	data;
	} csrWrite_t;

	typedef enum logic [1:0] {idle, writeResp, readResp} axiState_t;

endpackage

// File: hw/videoTxCsrTop.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module videoTxCsrTop
(
	input  logic							iSCLK,
	input  logic							iSRST,
	// axi4-lite slave
	input  videoTxCsrPkg::csrAddr_t			awaddr,
	input  logic							awvalid,
	output logic							awready,
	input  videoTxCsrPkg::csrData_t			wdata,
	input  logic [`VTX_DATA_W/8-1:0]		wstrb,
	input  logic							wvalid,
	output logic							wready,
	output logic [1:0]						bresp,
	output logic							bvalid,
	input  logic							bready,
	input  videoTxCsrPkg::csrAddr_t			araddr,
	input  logic							arvalid,
	output logic							arready,
	output videoTxCsrPkg::csrData_t			rdata,
	output logic [1:0]						rresp,
	output logic							rvalid,
	input  logic							rready,
	// side-band
	input  logic							dmaDone,
	input  logic							sceneAlphaMax,
	input  logic							sceneAlphaMin,
	input  videoTxCsrPkg::hPos_t			pixelH,
	input  videoTxCsrPkg::vPos_t			pixelV,
	output videoTxCsrPkg::dmaCfg_t			dmaCfg,
	output logic							vsgRst,
	output videoTxCsrPkg::tftCfg_t			tftCfg,
	output videoTxCsrPkg::mapCfg_t			mapCfg,
	output videoTxCsrPkg::sceneCfg_t		sceneCfg
);
	import videoTxCsrPkg::*;

	csrWrite_t	wrCmd;
	csrAddr_t	rdAddr;
	csrData_t	rdData;

	csrAxiSlave uAxiSlave
	(
		.iSCLK, .iSRST,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.wrCmd, .rdAddr, .rdData
	);

	csrRegFile uRegFile
	(
		.iSCLK, .iSRST, .wrCmd, .dmaDone,
		.dmaCfg, .vsgRst, .tftCfg, .mapCfg, .sceneCfg
	);

	csrReadMux uReadMux
	(
		.rdAddr, .dmaCfg, .vsgRst, .tftCfg, .mapCfg, .sceneCfg,
		.sceneAlphaMax, .sceneAlphaMin, .pixelH, .pixelV, .rdData
	);

endmodule

// File: hw/videoTxCsr_consts.svh
`ifndef VIDEO_TX_CSR_CONSTS_SVH
`define VIDEO_TX_CSR_CONSTS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define VTX_DATA_W			32
`define VTX_ADDR_W			12
`define VTX_DMA_ADDR_W		19
`define VTX_HPOS_W			11
`define VTX_VPOS_W			11
`define VTX_COLOR_W			32
`define VTX_SCENE_TIME_W	7
`define VTX_MAP_W			8
`define VTX_TFT_DATA_W		8
`define VTX_TFT_IM_W		4

// 480x272 panel in 16 px tiles
`define VTX_MAP_X_RST		8'd30
`define VTX_MAP_Y_RST		8'd17

`define VTX_RESP_OKAY		2'b00

// --------------------------------------------------
// register offsets
// --------------------------------------------------
`define VTX_REG_DMA_EN		12'h004
`define VTX_REG_DMA_CYCLE	12'h008
`define VTX_REG_DMA_START	12'h00C
`define VTX_REG_DMA_END		12'h010
`define VTX_REG_DMA_ADD		12'h014
`define VTX_REG_VSG			12'h020
`define VTX_REG_TFT_DATA	12'h050
`define VTX_REG_TFT_CTRL	12'h054	// {im, gate, cs, rs, rd, wr, rst}
`define VTX_REG_MAP			12'h100	// {xSize, ySize}
`define VTX_REG_SCENE_COLOR	12'h300
`define VTX_REG_SCENE_TIME	12'h304
`define VTX_REG_SCENE_CTRL	12'h308	// {frameRst, subEn, addEn}
`define VTX_REG_SCENE_STAT	12'h30C
`define VTX_REG_PIXEL_POS	12'h400

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f videoTxCsr.f \
	--top-module videoTxCsrTb \
	-o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
	exit 0
else
	exit 1
fi

// File: verif/videoTxCsrChecker.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module videoTxCsrChecker
(
	input  logic						iSCLK,
	input  logic						iSRST,
	input  videoTxCsrPkg::csrAddr_t		awaddr,
	input  logic						awvalid,
	input  logic						awready,
	input  videoTxCsrPkg::csrData_t		wdata,
	input  logic						wvalid,
	input  logic						wready,
	input  logic [1:0]					bresp,
	input  logic						bvalid,
	input  logic						bready,
	input  videoTxCsrPkg::csrAddr_t		araddr,
	input  logic						arvalid,
	input  logic						arready,
	input  videoTxCsrPkg::csrData_t		rdata,
	input  logic [1:0]					rresp,
	input  logic						rvalid,
	input  logic						rready,
	input  logic						dmaDone,
	input  logic						sceneAlphaMax,
	input  logic						sceneAlphaMin,
	input  videoTxCsrPkg::hPos_t		pixelH,
	input  videoTxCsrPkg::vPos_t		pixelV,
	input  videoTxCsrPkg::dmaCfg_t		dmaCfg,
	input  logic						vsgRst,
	input  videoTxCsrPkg::tftCfg_t		tftCfg,
	input  videoTxCsrPkg::mapCfg_t		mapCfg,
	input  videoTxCsrPkg::sceneCfg_t	sceneCfg
);
	import videoTxCsrPkg::*;

	logic [31:0]	regs [csrAddr_t];	// writable words after masking
	csrData_t		expRd[$];
	csrData_t		expWord;
	logic			oldCycle;
	int				errCount = 0;
	int				checkCount = 0;
	int				testBase = 0;
	int				testNum = 0;

	function void reportError(string msg);
		$display("[ERROR] %0t %s", $time, msg);
		errCount++;
	endfunction

	function void resetModel();
		regs[`VTX_REG_DMA_EN]		= 32'h0;
		regs[`VTX_REG_DMA_CYCLE]	= 32'h0;
		regs[`VTX_REG_DMA_START]	= 32'h0;
		regs[`VTX_REG_DMA_END]		= 32'h0007_ffff;
		regs[`VTX_REG_DMA_ADD]		= 32'h0;
		regs[`VTX_REG_VSG]			= 32'h1;
		regs[`VTX_REG_TFT_DATA]		= 32'h0;
		regs[`VTX_REG_TFT_CTRL]		= 32'h30;	// cs and gate high
		regs[`VTX_REG_MAP]			= 32'h1e11;	// 30 x 17
		regs[`VTX_REG_SCENE_COLOR]	= 32'h0;
		regs[`VTX_REG_SCENE_TIME]	= 32'h0;
		regs[`VTX_REG_SCENE_CTRL]	= 32'h4;	// frameRst
		expRd.delete();
	endfunction

	function automatic logic [31:0] fieldMask(csrAddr_t a);
		case (a)
			`VTX_REG_DMA_START, `VTX_REG_DMA_END, `VTX_REG_DMA_ADD:	return 32'h0007_ffff;
			`VTX_REG_TFT_DATA:		return 32'hff;
			`VTX_REG_TFT_CTRL:		return 32'h3ff;
			`VTX_REG_MAP:			return 32'hffff;
			`VTX_REG_SCENE_COLOR:	return 32'hffff_ffff;
			`VTX_REG_SCENE_TIME:	return 32'h7f;
			`VTX_REG_SCENE_CTRL:	return 32'h7;
			default:				return 32'h1;	// single-bit controls
		endcase
	endfunction

	function automatic csrData_t expectedRead(csrAddr_t a);
		if (regs.exists(a))
			return regs[a];
		if (a == `VTX_REG_SCENE_STAT)
			return {30'b0, sceneAlphaMax, sceneAlphaMin};
		if (a == `VTX_REG_PIXEL_POS)
			return {5'b0, pixelV, 5'b0, pixelH};
		return '0;
	endfunction

	// --------------------------------------------------
	// config outputs against the model words
	// --------------------------------------------------
	function void compareConfig();
		dmaCfg_t	eDma;
		tftCfg_t	eTft;
		mapCfg_t	eMap;
		sceneCfg_t	eScene;
		logic [31:0] c;
		eDma.enable = regs[`VTX_REG_DMA_EN][0];
		eDma.cycle = regs[`VTX_REG_DMA_CYCLE][0];
		eDma.startAddr = regs[`VTX_REG_DMA_START][18:0];
		eDma.endAddr = regs[`VTX_REG_DMA_END][18:0];
		eDma.stepAddr = regs[`VTX_REG_DMA_ADD][18:0];
		c = regs[`VTX_REG_TFT_CTRL];
		eTft.data = regs[`VTX_REG_TFT_DATA][7:0];
		eTft.rst = c[0];
		eTft.wr = c[1];
		eTft.rd = c[2];
		eTft.rs = c[3];
		eTft.cs = c[4];
		eTft.gate = c[5];
		eTft.im = c[9:6];
		eMap.xSize = regs[`VTX_REG_MAP][15:8];
		eMap.ySize = regs[`VTX_REG_MAP][7:0];
		c = regs[`VTX_REG_SCENE_CTRL];
		eScene.color = regs[`VTX_REG_SCENE_COLOR];
		eScene.timing = regs[`VTX_REG_SCENE_TIME][6:0];
		eScene.addEn = c[0];
		eScene.subEn = c[1];
		eScene.frameRst = c[2];
		checkCount++;
		if (dmaCfg !== eDma)
			reportError($sformatf("dmaCfg %h expected %h", dmaCfg, eDma));
		if (vsgRst !== regs[`VTX_REG_VSG][0])
			reportError($sformatf("vsgRst %b expected %b", vsgRst, regs[`VTX_REG_VSG][0]));
		if (tftCfg !== eTft)
			reportError($sformatf("tftCfg %h expected %h", tftCfg, eTft));
		if (mapCfg !== eMap)
			reportError($sformatf("mapCfg %h expected %h", mapCfg, eMap));
		if (sceneCfg !== eScene)
			reportError($sformatf("sceneCfg %h expected %h", sceneCfg, eScene));
	endfunction

	always @(posedge iSCLK)
	begin
		if (iSRST)
			resetModel();
		else
		begin
			if (rvalid && rready)
			begin
				if (rresp !== 2'b00)
					reportError($sformatf("rresp %b expected OKAY", rresp));
				if (expRd.size() == 0)
					reportError("read response arrived with no read accepted");
				else
				begin
					expWord = expRd.pop_front();
					checkCount++;
					if (rdata !== expWord)
						reportError($sformatf("read data %h expected %h", rdata, expWord));
				end
			end
			if (bvalid && bready)
			begin
				if (bresp !== 2'b00)
					reportError($sformatf("bresp %b expected OKAY", bresp));
				compareConfig();	// pre-edge state on both sides
			end
			if (arvalid && arready)
				expRd.push_back(expectedRead(araddr));
			oldCycle = regs[`VTX_REG_DMA_CYCLE][0];
			if (awvalid && awready && wvalid && wready && regs.exists(awaddr))
				regs[awaddr] = wdata & fieldMask(awaddr);
			if (dmaDone)
				regs[`VTX_REG_DMA_EN] = {31'b0, oldCycle};	// done wins
		end
	end

	function void endTest(string name);
		testNum++;
		$display("test %0d %s: %0d errors", testNum, name, errCount - testBase);
		testBase = errCount;
	endfunction

	function void finishRun();
		if (expRd.size() != 0)
		begin
			$display("%0d read responses never arrived", expRd.size());
			errCount++;
		end
		$display("tests %0d, checks %0d, errors %0d", testNum, checkCount, errCount);
	endfunction

endmodule

// File: verif/videoTxCsrTb.sv
`timescale 1ns/1ps
`include "videoTxCsr_consts.svh"

module videoTxCsrTb;
	import videoTxCsrPkg::*;

	localparam int NumTests = 5;
	localparam int TxnPerTest = 200;
	localparam int CyclesPerTxn = 40;
	localparam int ClkPeriod = 8;

	logic		iSCLK;
	logic		iSRST;
	csrAddr_t	awaddr;
	logic		awvalid;
	logic		awready;
	csrData_t	wdata;
	logic [3:0]	wstrb;
	logic		wvalid;
	logic		wready;
	logic [1:0]	bresp;
	logic		bvalid;
	logic		bready;
	csrAddr_t	araddr;
	logic		arvalid;
	logic		arready;
	csrData_t	rdata;
	logic [1:0]	rresp;
	logic		rvalid;
	logic		rready;
	logic		dmaDone;
	logic		sceneAlphaMax;
	logic		sceneAlphaMin;
	hPos_t		pixelH;
	vPos_t		pixelV;
	dmaCfg_t	dmaCfg;
	logic		vsgRst;
	tftCfg_t	tftCfg;
	mapCfg_t	mapCfg;
	sceneCfg_t	sceneCfg;

	logic			backPressure = 1'b0;
	logic			doneOn = 1'b0;
	logic			statusOn = 1'b0;
	logic [31:0]	sideRnd;

	videoTxCsrTop u_dut (.*);

	videoTxCsrChecker u_chk (.*);

	initial
	begin
		iSCLK = 1'b0;
		forever #(ClkPeriod/2) iSCLK = ~iSCLK;
	end

	initial
	begin
		#(NumTests * TxnPerTest * CyclesPerTxn * ClkPeriod);
		$display("timeout: test sequence did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	// --------------------------------------------------
	// side-band stimulus
	// --------------------------------------------------
	always @(posedge iSCLK)
	begin
		#1;
		sideRnd = $urandom;
		dmaDone = doneOn && (sideRnd[1:0] == 2'b00);
		if (statusOn)
		begin
			sceneAlphaMax = sideRnd[2];
			sceneAlphaMin = sideRnd[3];
			pixelH = sideRnd[14:4];
			pixelV = sideRnd[25:15];
		end
	end

	function automatic logic readyDraw();
		if (backPressure)
			return ($urandom % 3 == 0);
		return 1'b1;
	endfunction

	// writable offsets first, then the two status words
	function automatic csrAddr_t mappedOffset(int idx);
		case (idx)
			0:			return `VTX_REG_DMA_EN;
			1:			return `VTX_REG_DMA_CYCLE;
			2:			return `VTX_REG_DMA_START;
			3:			return `VTX_REG_DMA_END;
			4:			return `VTX_REG_DMA_ADD;
			5:			return `VTX_REG_VSG;
			6:			return `VTX_REG_TFT_DATA;
			7:			return `VTX_REG_TFT_CTRL;
			8:			return `VTX_REG_MAP;
			9:			return `VTX_REG_SCENE_COLOR;
			10:			return `VTX_REG_SCENE_TIME;
			11:			return `VTX_REG_SCENE_CTRL;
			12:			return `VTX_REG_SCENE_STAT;
			default:	return `VTX_REG_PIXEL_POS;
		endcase
	endfunction

	function automatic csrAddr_t unmappedOffset();
		csrAddr_t a;
		logic hit;
		do
		begin
			a = {10'($urandom), 2'b00};
			hit = 1'b0;
			for (int i = 0; i < 14; i++)
				if (mappedOffset(i) == a)
					hit = 1'b1;
		end
		while (hit);
		return a;
	endfunction

	// --------------------------------------------------
	// AXI4-Lite master
	// --------------------------------------------------
	task automatic axiWrite(input csrAddr_t addr, input csrData_t data);
		@(posedge iSCLK);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = 4'($urandom);	// ignored by the slave
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
			@(posedge iSCLK);
		while (!(awready && wready));
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = readyDraw();
		@(posedge iSCLK);
		while (!(bvalid && bready))
		begin
			#1 bready = readyDraw();
			@(posedge iSCLK);
		end
	endtask

	task automatic axiRead(input csrAddr_t addr);
		@(posedge iSCLK);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		do
			@(posedge iSCLK);
		while (!arready);
		#1;
		arvalid = 1'b0;
		rready = readyDraw();
		@(posedge iSCLK);
		while (!(rvalid && rready))
		begin
			#1 rready = readyDraw();
			@(posedge iSCLK);
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		csrAddr_t a;
		void'($urandom(32'h8f40_e6d1));
		iSRST = 1'b1;
		{awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
		{araddr, arvalid, rready, dmaDone} = '0;
		{sceneAlphaMax, sceneAlphaMin, pixelH, pixelV} = '0;
		repeat (2) @(posedge iSCLK);
		#1 iSRST = 1'b0;

		#1 u_chk.compareConfig();
		for (int i = 0; i < 14; i++)
			axiRead(mappedOffset(i));
		u_chk.endTest("reset values");

		repeat (90)
		begin
			a = mappedOffset($urandom % 12);
			axiWrite(a, $urandom);
			axiRead(a);
		end
		u_chk.endTest("random write and readback");

		doneOn = 1'b1;
		repeat (60)
		begin
			a = ($urandom % 2 == 0) ? `VTX_REG_DMA_EN : `VTX_REG_DMA_CYCLE;
			axiWrite(a, $urandom);
			axiRead(`VTX_REG_DMA_EN);
		end
		doneOn = 1'b0;
		u_chk.endTest("dma done reload");

		backPressure = 1'b1;
		repeat (60)
		begin
			axiWrite(mappedOffset($urandom % 14), $urandom);
			axiRead(mappedOffset($urandom % 14));
		end
		backPressure = 1'b0;
		u_chk.endTest("response back-pressure");

		statusOn = 1'b1;
		repeat (40)
		begin
			axiRead(`VTX_REG_SCENE_STAT);
			axiRead(`VTX_REG_PIXEL_POS);
			a = unmappedOffset();
			axiWrite(a, $urandom);
			axiRead(a);
		end
		statusOn = 1'b0;
		u_chk.endTest("status and unmapped offsets");

		repeat (4) @(posedge iSCLK);
		u_chk.finishRun();
		if (u_chk.errCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verif/videoTxCsr_sva.sv
`timescale 1ns/1ps

module videoTxCsrAssertions
(
	input  logic						iSCLK,
	input  logic						iSRST,
	input  logic						awready,
	input  logic						wready,
	input  logic						arready,
	input  logic						bvalid,
	input  logic						bready,
	input  logic						rvalid,
	input  logic						rready,
	input  videoTxCsrPkg::csrData_t		rdata
);

	// --------------------------------------------------
	// response channels
	// --------------------------------------------------
	bHeld: assert property (@(posedge iSCLK) disable iff (iSRST)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rHeld: assert property (@(posedge iSCLK) disable iff (iSRST)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	// one transaction in flight
	noReadyWhileBusy: assert property (@(posedge iSCLK) disable iff (iSRST)
		(bvalid || rvalid) |-> !(awready || wready || arready))
		else $error("request accepted while a response is pending");

	quietAfterReset: assert property (@(posedge iSCLK)
		iSRST |=> !bvalid && !rvalid)
		else $error("valid high in the cycle after reset");

endmodule

bind csrAxiSlave videoTxCsrAssertions uSva
(
	.iSCLK(iSCLK), .iSRST(iSRST),
	.awready(awready), .wready(wready), .arready(arready),
	.bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata)
);

// File: videoTxCsr.f
+incdir+hw
hw/videoTxCsrPkg.sv
hw/csrAxiSlave.sv
hw/csrRegFile.sv
hw/csrReadMux.sv
hw/videoTxCsrTop.sv
verif/videoTxCsr_sva.sv
verif/videoTxCsrChecker.sv
verif/videoTxCsrTb.sv
